// File: src.f
+incdir+tests
design/usbRxPkg.sv
design/usbLineSync.sv
design/usbBitDecoder.sv
design/usbLineStateDetect.sv
design/usbPacketAssembler.sv
design/usbRxFrontEnd.sv
tests/usbRxFrontEndTb.sv

// File: tests/usbRxStimulus.svh
// Included in the testbench module body; payload byte 0 sits in bits [7:0]
`ifndef USB_RX_STIMULUS_SVH
`define USB_RX_STIMULUS_SVH

localparam int maxRows = 20;

string       rowName[maxRows];
logic [63:0] rowPayload[maxRows];
int          rowCount[maxRows];
logic        rowForceStuffError[maxRows];
int          rowTruncateBits[maxRows];
int          rowSe0Len[maxRows];
logic        rowExpOk[maxRows];
logic        rowExpReset[maxRows];
int          numRows = 0;
integer      seed = 32'he158_65e8;

usbRxPkg::lineState_t lineSeq[$];
usbRxPkg::lineState_t curLevel;
int                   oneRun;
logic                 stuffOn;

task automatic addRow(input string name, input logic [63:0] payload, input int count,
                      input logic useRandom, input logic forceErr, input int truncBits,
                      input int se0Len, input logic expOk, input logic expReset);
    rowName[numRows] = name;
    rowPayload[numRows] = payload;
    if (useRandom) begin
        rowPayload[numRows] = {$random(seed), $random(seed)};
    end
    rowCount[numRows] = count;
    rowForceStuffError[numRows] = forceErr;
    rowTruncateBits[numRows] = truncBits;
    rowSe0Len[numRows] = se0Len;
    rowExpOk[numRows] = expOk;
    rowExpReset[numRows] = expReset;
    numRows++;
endtask

task automatic loadTable();
    //     name               payload                 cnt rnd err trn se0 ok rst
    addRow("plainOneByte",    64'h00000000_000000C3, 1,  0,  0,  0,  3,  1, 0);
    addRow("plainFourBytes",  64'h00000000_2D0F5AA5, 4,  0,  0,  0,  3,  1, 0);
    addRow("plainEightBytes", 64'h01234567_89ABCDEF, 8,  0,  0,  0,  3,  1, 0);
    addRow("randomEight",     64'h0,                 8,  1,  0,  0,  3,  1, 0);
    addRow("randomFive",      64'h0,                 5,  1,  0,  0,  3,  1, 0);
    addRow("randomThree",     64'h0,                 3,  1,  0,  0,  3,  1, 0);
    addRow("stuffAllOnes",    64'h00000000_FFFFFFFF, 4,  0,  0,  0,  3,  1, 0);
    addRow("stuffRun7E",      64'h00007E7E_7E7E7E7E, 6,  0,  0,  0,  3,  1, 0);
    addRow("stuffMixed",      64'h7E3FFCFF_00FFFF7F, 8,  0,  0,  0,  3,  1, 0);
    addRow("longSe0Eop",      64'h00000000_0000A55A, 2,  0,  0,  0,  6,  1, 0);
    addRow("stuffErrorShort", 64'h00000000_000000FF, 2,  0,  1,  0,  3,  0, 0);
    addRow("stuffErrorLong",  64'h00000000_12FFFFFF, 4,  0,  1,  0,  3,  0, 0);
    addRow("truncateOne",     64'h00000000_00003C81, 2,  0,  0,  1,  3,  0, 0);
    addRow("truncateSeven",   64'h00000000_00E71842, 3,  0,  0,  7,  3,  0, 0);
    addRow("truncateFour",    64'h00000000_00000099, 1,  0,  0,  4,  3,  0, 0);
    addRow("se0Short",        64'h0,                 0,  0,  0,  0,  119, 0, 0);
    addRow("se0BusReset",     64'h00000000_00003C5A, 2,  0,  0,  0,  130, 0, 1);
    addRow("afterBusReset",   64'h00000000_00C0FFEE, 3,  0,  0,  0,  3,  1, 0);
endtask

task automatic pushLevel(input usbRxPkg::lineState_t level, input int n);
    for (int i = 0; i < n; i++) begin
        lineSeq.push_back(level);
    end
endtask

// A 0 toggles the NRZI line and a 1 holds it
task automatic pushBit(input logic b);
    if (!b) begin
        curLevel = (curLevel == usbRxPkg::J) ? usbRxPkg::K : usbRxPkg::J;
    end
    lineSeq.push_back(curLevel);
endtask

task automatic pushDataBit(input logic b);
    pushBit(b);
    oneRun = b ? oneRun + 1 : 0;
    if (stuffOn && oneRun == usbRxPkg::stuffRunLength) begin
        pushBit(1'b0);
        oneRun = 0;
    end
endtask

task automatic buildSequence(input int row);
    logic [7:0] syncBits;
    logic [7:0] extraBits;
    syncBits = usbRxPkg::syncByte;
    extraBits = 8'hA5;
    lineSeq.delete();
    // Idle long enough that the decoder's run counter has overflowed
    pushLevel(usbRxPkg::J, 16);
    if (rowCount[row] > 0) begin
        curLevel = usbRxPkg::J;
        oneRun = 0;
        stuffOn = !rowForceStuffError[row];
        for (int i = 0; i < 8; i++) begin
            pushDataBit(syncBits[i]);
        end
        for (int n = 0; n < rowCount[row]; n++) begin
            for (int i = 0; i < 8; i++) begin
                pushDataBit(rowPayload[row][8*n+i]);
            end
        end
        for (int i = 0; i < rowTruncateBits[row]; i++) begin
            pushDataBit(extraBits[i]);
        end
    end
    pushLevel(usbRxPkg::Se0, rowSe0Len[row]);
    pushLevel(usbRxPkg::J, 8);
endtask

// Stuffed zeros are dropped by the receiver and a short tail never completes a byte
function automatic logic [7:0] expectedByte(input int row, input int idx);
    return rowPayload[row][8*idx +: 8];
endfunction

`endif

// File: tests/usbRxFrontEndTb.sv
// One pin sample per bit cell at clk48; SE0 lengths in the table assume resetSe0Cycles of 120
`timescale 1ns/100ps
`default_nettype none

module usbRxFrontEndTb;

    localparam int resetSe0Cycles = 120;
    localparam int timeoutCycles = 2000;

    logic       clk48;
    logic       ACK_USB_RST;
    logic       dp;
    logic       dn;
    logic [7:0] rxByte;
    logic       rxByteValid;
    logic       packetEnd;
    logic       packetOk;
    logic       rxActive;
    logic       usbReset;

    logic [7:0] gotBytes[$];
    int         endCount = 0;
    logic       lastOk = 1'b0;
    int         errorCount = 0;
    int         testsPassed = 0;
    int         testsFailed = 0;

    `include "usbRxStimulus.svh"

    usbRxFrontEnd #(
        .resetSe0Cycles (resetSe0Cycles)
    ) usbRxFrontEnd_i (
        .clk48       (clk48),
        .ACK_USB_RST (ACK_USB_RST),
        .dp          (dp),
        .dn          (dn),
        .rxByte      (rxByte),
        .rxByteValid (rxByteValid),
        .packetEnd   (packetEnd),
        .packetOk    (packetOk),
        .rxActive    (rxActive),
        .usbReset    (usbReset)
    );

    initial begin
        clk48 = 1'b0;
        forever begin
            #2 clk48 = ~clk48;
        end
    end

    // Registered outputs are sampled at the falling edge
    always @(negedge clk48) begin
        if (rxByteValid) begin
            gotBytes.push_back(rxByte);
        end
        if (packetEnd) begin
            endCount++;
            lastOk = packetOk;
        end
    end

    function automatic logic [1:0] pinsFor(input usbRxPkg::lineState_t s);
        case (s)
            usbRxPkg::J:   return 2'b10;
            usbRxPkg::K:   return 2'b01;
            usbRxPkg::Se0: return 2'b00;
            default:       return 2'b11;
        endcase
    endfunction

    task automatic compareValue(input string testName, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s:%s expected 0x%0h actual 0x%0h",
                     testName, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic driveLevel(input usbRxPkg::lineState_t s);
        @(posedge clk48);
        #1;
        {dp, dn} = pinsFor(s);
    endtask

    task automatic playSequence();
        foreach (lineSeq[i]) begin
            driveLevel(lineSeq[i]);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveLevel(usbRxPkg::J);
    endtask

    task automatic pulseReset(input int n);
        @(posedge clk48);
        #1;
        ACK_USB_RST = 1'b1;
        repeat (n) @(posedge clk48);
        #1;
        ACK_USB_RST = 1'b0;
    endtask

    task automatic waitPacketEnd(input string testName, input int startCount);
        int cycles;
        cycles = 0;
        while (endCount == startCount && cycles < timeoutCycles) begin
            @(posedge clk48);
            #1;
            cycles++;
        end
        if (endCount == startCount) begin
            $display("%s: packetEnd never came within %0d cycles", testName, timeoutCycles);
            errorCount++;
        end
    endtask

    task automatic waitUsbReset(input string testName);
        int cycles;
        cycles = 0;
        while (!usbReset && cycles < timeoutCycles) begin
            @(posedge clk48);
            #1;
            cycles++;
        end
        if (!usbReset) begin
            $display("%s: usbReset never rose within %0d cycles", testName, timeoutCycles);
            errorCount++;
        end
    endtask

    task automatic runPacketRow(input int row);
        int startEnd;
        string name;
        name = rowName[row];
        startEnd = endCount;
        gotBytes.delete();
        buildSequence(row);
        playSequence();
        waitPacketEnd(name, startEnd);
        // A few more idle cycles would reveal a second packetEnd
        idleCycles(4);
        compareValue(name, "packetEnd count", 1, endCount - startEnd);
        compareValue(name, "packetOk", rowExpOk[row], lastOk);
        compareValue(name, "byte count", rowCount[row], gotBytes.size());
        for (int i = 0; i < rowCount[row] && i < gotBytes.size(); i++) begin
            compareValue(name, $sformatf("byte %0d", i), expectedByte(row, i), gotBytes[i]);
        end
        compareValue(name, "rxActive", 0, rxActive);
    endtask

    task automatic runLineRow(input int row);
        int startEnd;
        string name;
        name = rowName[row];
        startEnd = endCount;
        buildSequence(row);
        playSequence();
        if (rowExpReset[row]) begin
            waitUsbReset(name);
            idleCycles(20);
            compareValue(name, "usbReset held", 1, usbReset);
            pulseReset(10);
            compareValue(name, "usbReset after ack", 0, usbReset);
        end else begin
            compareValue(name, "usbReset", 0, usbReset);
        end
        compareValue(name, "packetEnd count", 0, endCount - startEnd);
    endtask

    task automatic finishTest(input string testName, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("test %s passed", testName);
        end else begin
            testsFailed++;
            $display("test %s failed", testName);
        end
    endtask

    initial begin
        int errorsBefore;
        ACK_USB_RST = 1'b1;
        dp = 1'b1;
        dn = 1'b0;
        loadTable();
        repeat (10) @(posedge clk48);
        #1;
        ACK_USB_RST = 1'b0;

        // Quiet outputs after reset and through idle J
        errorsBefore = errorCount;
        compareValue("resetState", "rxByteValid", 0, rxByteValid);
        compareValue("resetState", "packetEnd", 0, packetEnd);
        compareValue("resetState", "packetOk", 0, packetOk);
        compareValue("resetState", "rxActive", 0, rxActive);
        compareValue("resetState", "usbReset", 0, usbReset);
        idleCycles(20);
        compareValue("resetState", "bytes during idle", 0, gotBytes.size());
        compareValue("resetState", "packetEnd count", 0, endCount);
        finishTest("resetState", errorsBefore);

        for (int row = 0; row < numRows; row++) begin
            errorsBefore = errorCount;
            // A bus-reset row aborts its packet, so no packetEnd is awaited
            if (rowCount[row] > 0 && !rowExpReset[row]) begin
                runPacketRow(row);
            end else begin
                runLineRow(row);
            end
            finishTest(rowName[row], errorsBefore);
        end

        $display("tests passed %0d failed %0d", testsPassed, testsFailed);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/usbRxFrontEnd.sv
// Receive only, full speed, one sample per bit; resetSe0Cycles sets the bus-reset SE0 length
`timescale 1ns/100ps
`default_nettype none

module usbRxFrontEnd #(
    parameter int resetSe0Cycles = 120
) (
    input  wire logic        clk48,
    input  wire logic        ACK_USB_RST,
    input  wire logic        dp,
    input  wire logic        dn,
    output logic [7:0]       rxByte,
    output logic             rxByteValid,
    output logic             packetEnd,
    output logic             packetOk,
    output logic             rxActive,
    output logic             usbReset
);

    usbRxPkg::lineState_t lineState;
    logic                 bitValid;
    logic                 bitData;
    logic                 stuffError;
    logic                 eop;
    logic                 eopClear;

    usbLineSync usbLineSync_i (
        .clk48       (clk48),
        .ACK_USB_RST (ACK_USB_RST),
        .dp          (dp),
        .dn          (dn),
        .lineState   (lineState)
    );

    usbBitDecoder usbBitDecoder_i (
        .clk48       (clk48),
        .ACK_USB_RST (ACK_USB_RST),
        .lineState   (lineState),
        .bitValid    (bitValid),
        .bitData     (bitData),
        .stuffError  (stuffError)
    );

    usbLineStateDetect #(
        .resetSe0Cycles (resetSe0Cycles)
    ) usbLineStateDetect_i (
        .clk48       (clk48),
        .ACK_USB_RST (ACK_USB_RST),
        .lineState   (lineState),
        .eopClear    (eopClear),
        .eop         (eop),
        .usbReset    (usbReset)
    );

    usbPacketAssembler usbPacketAssembler_i (
        .clk48       (clk48),
        .ACK_USB_RST (ACK_USB_RST),
        .bitValid    (bitValid),
        .bitData     (bitData),
        .stuffError  (stuffError),
        .eop         (eop),
        .usbReset    (usbReset),
        .eopClear    (eopClear),
        .rxByte      (rxByte),
        .rxByteValid (rxByteValid),
        .packetEnd   (packetEnd),
        .packetOk    (packetOk),
        .rxActive    (rxActive)
    );

endmodule

`default_nettype wire

// File: design/usbPacketAssembler.sv
// No back-pressure: bytes must be taken when strobed; CRC and PID are not checked
`timescale 1ns/100ps
`default_nettype none

module usbPacketAssembler (
    input  wire logic        clk48,
    input  wire logic        ACK_USB_RST,
    input  wire logic        bitValid,
    input  wire logic        bitData,
    input  wire logic        stuffError,
    input  wire logic        eop,
    input  wire logic        usbReset,
    output logic             eopClear,
    output logic [7:0]       rxByte,
    output logic             rxByteValid,
    output logic             packetEnd,
    output logic             packetOk,
    output logic             rxActive
);

    logic [7:0] syncWindow;
    logic [7:0] nextWindow;
    logic [7:0] shiftReg;
    logic [2:0] bitCount;
    logic       errFlag;
    logic       syncMatch;

    // Bits arrive LSB first, so shift in from the top
    assign nextWindow = {bitData, syncWindow[7:1]};
    assign syncMatch = !rxActive && !usbReset && bitValid && (nextWindow == usbRxPkg::syncByte);

    // Clears a stale eop on the same edge that opens the packet
    assign eopClear = syncMatch;

    always_ff @(posedge clk48) begin
        if (ACK_USB_RST) begin
            syncWindow  <= 8'hFF;
            bitCount    <= '0;
            errFlag     <= 1'b0;
            rxByteValid <= 1'b0;
            packetEnd   <= 1'b0;
            packetOk    <= 1'b0;
            rxActive    <= 1'b0;
        end else begin
            rxByteValid <= 1'b0;
            packetEnd   <= 1'b0;
            if (usbReset) begin
                // Bus reset drops the packet silently
                rxActive   <= 1'b0;
                syncWindow <= 8'hFF;
            end else if (!rxActive) begin
                if (bitValid) begin
                    syncWindow <= nextWindow;
                end
                if (syncMatch) begin
                    rxActive <= 1'b1;
                    bitCount <= '0;
                    errFlag  <= 1'b0;
                    packetOk <= 1'b0;
                end
            end else if (eop) begin
                // The EOP J bit arriving now is not data
                packetEnd  <= 1'b1;
                packetOk   <= !errFlag && !stuffError && (bitCount == 3'd0);
                rxActive   <= 1'b0;
                syncWindow <= 8'hFF;
            end else begin
                if (stuffError) begin
                    errFlag <= 1'b1;
                end
                if (bitValid) begin
                    bitCount <= bitCount + 1'b1;
                    if (bitCount == 3'd7) begin
                        rxByteValid <= 1'b1;
                    end
                end
            end
        end
    end

    // Payload path
    always_ff @(posedge clk48) begin
        if (rxActive && !eop && bitValid) begin
            shiftReg <= {bitData, shiftReg[7:1]};
            if (bitCount == 3'd7) begin
                rxByte <= {bitData, shiftReg[7:1]};
            end
        end
    end

    byteAndEndApart: assert property (
        @(posedge clk48) disable iff (ACK_USB_RST)
        !(rxByteValid && packetEnd)
    );

endmodule

`default_nettype wire

// File: design/usbLineStateDetect.sv
// EOP needs three or more SE0 samples then J (one stray sample allowed); reset flag stays until ACK
`timescale 1ns/100ps
`default_nettype none

module usbLineStateDetect #(
    parameter int resetSe0Cycles = 120
) (
    input  wire logic                 clk48,
    input  wire logic                 ACK_USB_RST,
    input  wire usbRxPkg::lineState_t lineState,
    input  wire logic                 eopClear,
    output logic                      eop,
    output logic                      usbReset
);

    localparam int se0CountWidth = $clog2(resetSe0Cycles + 1);
    localparam logic [se0CountWidth-1:0] se0Limit = se0CountWidth'(resetSe0Cycles);

    typedef enum logic [2:0] {
        Idle,
        FirstSe0,
        SecondSe0,
        ThirdSe0,
        LastChance
    } eopState_t;

    eopState_t                state, nextState;
    logic                     se0, isJ;
    logic                     eopSet, nextEop, nextUsbReset;
    logic [se0CountWidth-1:0] se0Count;

    assign se0 = (lineState == usbRxPkg::Se0);
    assign isJ = (lineState == usbRxPkg::J);

    always_comb begin
        nextState = state;
        eopSet    = 1'b0;
        case (state)
            Idle: begin
                if (se0) begin
                    nextState = FirstSe0;
                end
            end
            FirstSe0: begin
                nextState = se0 ? SecondSe0 : Idle;
            end
            SecondSe0: begin
                nextState = se0 ? ThirdSe0 : Idle;
            end
            ThirdSe0: begin
                // Long SE0 stays here; one non-J sample gets a last chance
                if (isJ) begin
                    eopSet    = 1'b1;
                    nextState = Idle;
                end else if (!se0) begin
                    nextState = LastChance;
                end
            end
            LastChance: begin
                eopSet    = isJ;
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    assign nextEop = (eop && !eopClear) || eopSet;
    assign nextUsbReset = usbReset || (se0Count == se0Limit);

    always_ff @(posedge clk48) begin
        if (ACK_USB_RST) begin
            state    <= Idle;
            eop      <= 1'b0;
            usbReset <= 1'b0;
            se0Count <= '0;
        end else begin
            state    <= nextState;
            eop      <= nextEop;
            usbReset <= nextUsbReset;
            // Saturating run length of SE0
            if (!se0) begin
                se0Count <= '0;
            end else if (se0Count != se0Limit) begin
                se0Count <= se0Count + 1'b1;
            end
        end
    end

    eopFromFsm: assert property (
        @(posedge clk48) disable iff (ACK_USB_RST)
        $rose(eop) |-> ($past(state) == ThirdSe0) || ($past(state) == LastChance)
    );

endmodule

`default_nettype wire

// File: design/usbBitDecoder.sv
// NRZI decode and unstuffing only; SE0/SE1 give no bit, and a run of 1s past the limit flags once
`timescale 1ns/100ps
`default_nettype none

module usbBitDecoder (
    input  wire logic                 clk48,
    input  wire logic                 ACK_USB_RST,
    input  wire usbRxPkg::lineState_t lineState,
    output logic                      bitValid,
    output logic                      bitData,
    output logic                      stuffError
);

    // One extra count value marks a run that already overflowed
    localparam int countWidth = $clog2(usbRxPkg::stuffRunLength + 2);
    localparam logic [countWidth-1:0] runLimit = countWidth'(usbRxPkg::stuffRunLength);
    localparam logic [countWidth-1:0] runOver = countWidth'(usbRxPkg::stuffRunLength + 1);

    usbRxPkg::lineState_t  prevLevel;
    logic [countWidth-1:0] oneCount;
    logic                  isData;
    logic                  rawBit;

    assign isData = (lineState == usbRxPkg::J) || (lineState == usbRxPkg::K);

    // No NRZI transition decodes as a 1
    assign rawBit = (lineState == prevLevel);

    always_ff @(posedge clk48) begin
        if (ACK_USB_RST) begin
            prevLevel  <= usbRxPkg::J;
            oneCount   <= '0;
            bitValid   <= 1'b0;
            stuffError <= 1'b0;
        end else begin
            bitValid   <= 1'b0;
            stuffError <= 1'b0;
            if (!isData) begin
                // Line returns to idle J after SE0
                prevLevel <= usbRxPkg::J;
                oneCount  <= '0;
            end else begin
                prevLevel <= lineState;
                if (!rawBit) begin
                    oneCount <= '0;
                    // Zero after a full run is the stuffed bit
                    bitValid <= (oneCount != runLimit);
                end else begin
                    bitValid <= 1'b1;
                    if (oneCount == runLimit) begin
                        stuffError <= 1'b1;
                        oneCount   <= runOver;
                    end else if (oneCount != runOver) begin
                        oneCount <= oneCount + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (isData) begin
            bitData <= rawBit;
        end
    end

    // SE0 never produces a data bit in the next cycle
    noBitAfterSe0: assert property (
        @(posedge clk48) disable iff (ACK_USB_RST)
        (lineState == usbRxPkg::Se0) |=> !bitValid
    );

endmodule

`default_nettype wire

// File: design/usbLineSync.sv
// Pins are sampled once per bit cell at clk48; two cycles from a pin change to lineState
`timescale 1ns/100ps
`default_nettype none

module usbLineSync (
    input  wire logic                 clk48,
    input  wire logic                 ACK_USB_RST,
    input  wire logic                 dp,
    input  wire logic                 dn,
    output usbRxPkg::lineState_t      lineState
);

    logic dpMeta, dpSync;
    logic dnMeta, dnSync;

    // Two flops per pin against metastability, idle J during reset
    always_ff @(posedge clk48) begin
        if (ACK_USB_RST) begin
            dpMeta <= 1'b1;
            dpSync <= 1'b1;
            dnMeta <= 1'b0;
            dnSync <= 1'b0;
        end else begin
            dpMeta <= dp;
            dpSync <= dpMeta;
            dnMeta <= dn;
            dnSync <= dnMeta;
        end
    end

    always_comb begin
        case ({dpSync, dnSync})
            2'b00:   lineState = usbRxPkg::Se0;
            2'b01:   lineState = usbRxPkg::K;
            2'b10:   lineState = usbRxPkg::J;
            default: lineState = usbRxPkg::Se1;
        endcase
    end

endmodule

`default_nettype wire

// File: design/usbRxPkg.sv
// Full-speed polarity only (J = D+ high); constants are shared by the RTL and the testbench
`default_nettype none

package usbRxPkg;

    // Encoding follows the {dp, dn} pin pair
    typedef enum logic [1:0] {
        Se0 = 2'b00,
        K   = 2'b01,
        J   = 2'b10,
        Se1 = 2'b11
    } lineState_t;

    // SYNC as received LSB first: seven 0 bits followed by a 1
    localparam logic [7:0] syncByte = 8'h80;

    // A stuffed 0 follows this many consecutive 1 bits
    localparam int stuffRunLength = 6;

endpackage

`default_nettype wire
